// File: vlog.f
cpuPkg.sv
wbIf.sv
regFile.sv
alu.sv
memUnit.sv
wbRam.sv
datapath.sv
datapath_asserts.sv
datapath_tb.sv

// File: Bender.yml
package:
  name: datapath

sources:
  - cpuPkg.sv
  - wbIf.sv
  - regFile.sv
  - alu.sv
  - memUnit.sv
  - wbRam.sv
  - datapath.sv
  - target: test
    files:
      - datapath_asserts.sv
      - datapath_tb.sv

// File: datapath_tb.sv
module datapath_tb import cpuPkg::*;;

    localparam int resetCycles = 16;
    localparam int memLimit    = 10;     // cycles allowed for one access
    localparam int maxSteps    = 256;

    // select bits, packed as {gra, grb, grc, rin, rout, baOut}
    localparam logic [5:0] gA   = 6'b100000;
    localparam logic [5:0] gB   = 6'b010000;
    localparam logic [5:0] gC   = 6'b001000;
    localparam logic [5:0] rIn  = 6'b000100;
    localparam logic [5:0] rOut = 6'b000010;
    localparam logic [5:0] bOut = 6'b000001;

    typedef struct packed {
        logic [numLoads-1:0] ld;
        busSrcE              src;
        aluOpE               op;
        logic [5:0]          sel;
        logic                rd;
        logic                wr;
        logic                mdRd;
        logic [dataW-1:0]    inData;
        logic [1:0]          chk;        // 0 none, 1 busOut, 2 outPort
        logic [dataW-1:0]    exp;
        logic                waitDone;   // wait for memDone after this step
        logic                rst;        // mid-run reset pulse
    } stepT;

    logic                clk;
    logic                rstN;
    logic [numLoads-1:0] loadEn;
    busSrcE              busSrc;
    aluOpE               aluOp;
    logic                gra, grb, grc, rin, rout, baOut;
    logic                memRead, memWrite, mdRead;
    logic [dataW-1:0]    inPortData;
    logic [dataW-1:0]    busOut;
    logic [dataW-1:0]    outPort;
    logic                memDone;

    stepT   steps [maxSteps];
    stepT   s;                 // step under construction
    int     nSteps;
    int     errors;
    bit     built;
    integer seed;

    datapath #(.memWords(256)) u_dut (
        .clk(clk), .rstN(rstN), .loadEn(loadEn), .busSrc(busSrc), .aluOp(aluOp),
        .gra(gra), .grb(grb), .grc(grc), .rin(rin), .rout(rout), .baOut(baOut),
        .memRead(memRead), .memWrite(memWrite), .mdRead(mdRead),
        .inPortData(inPortData), .busOut(busOut), .outPort(outPort), .memDone(memDone)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopOnFailure();
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            stopOnFailure();
        end
    endtask

    function automatic logic [numLoads-1:0] ldMask(input loadE p);
        return numLoads'(1) << p;
    endfunction

    // reference ALU, straight from the opcode rules
    function automatic logic [63:0] aluModel(input aluOpE op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] w;
        int          sa;
        int          sb;
        longint      p;
        sa = a;
        sb = b;
        w  = '0;
        case (op)
            opAdd:  w = a + b;
            opSub:  w = a - b;
            opAnd:  w = a & b;
            opOr:   w = a | b;
            opXor:  w = a ^ b;
            opShl:  w = a << b[4:0];
            opShr:  w = a >> b[4:0];
            opShra: w = sa >>> b[4:0];
            opNeg:  w = 32'd0 - b;
            opNot:  w = ~b;
            opInc4: w = b + 32'd4;
            opMul: begin
                p = longint'(sa) * longint'(sb);
                return p;
            end
            opDiv: begin
                if (b == 32'd0) begin
                    return {a, 32'hFFFF_FFFF};   // rem = dividend, quot all ones
                end
                return {32'(sa % sb), 32'(sa / sb)};
            end
            default: w = '0;
        endcase
        return {{32{w[31]}}, w};
    endfunction

    task automatic clearStep();
        s     = '0;
        s.src = srcGpr;
        s.op  = opAdd;
    endtask

    task automatic pushStep();
        steps[nSteps] = s;
        nSteps++;
    endtask

    task automatic putIn(input logic [31:0] v);     // inPort <- v
        clearStep();
        s.ld     = ldMask(ldInPort);
        s.inData = v;
        pushStep();
    endtask

    task automatic moveIn(input logic [numLoads-1:0] ld, input logic [5:0] sel);
        clearStep();
        s.src = srcInPort;
        s.ld  = ld;
        s.sel = sel;
        pushStep();
    endtask

    task automatic expectBus(input busSrcE src, input logic [5:0] sel, input logic [31:0] v);
        clearStep();
        s.src = src;
        s.sel = sel;
        s.chk = 2'd1;
        s.exp = v;
        pushStep();
    endtask

    task automatic memStep(input logic isWrite);
        clearStep();
        s.rd       = !isWrite;
        s.wr       = isWrite;
        s.waitDone = 1'b1;
        pushStep();
    endtask

    task automatic aluCase(input aluOpE op, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] z;
        z = aluModel(op, a, b);
        putIn(a);
        clearStep();                                // Y <- a, inPort <- b
        s.src    = srcInPort;
        s.ld     = ldMask(ldY) | ldMask(ldInPort);
        s.inData = b;
        pushStep();
        clearStep();                                // Z <- a op b
        s.src = srcInPort;
        s.ld  = ldMask(ldZ);
        s.op  = op;
        pushStep();
        expectBus(srcZLo, '0, z[31:0]);
        expectBus(srcZHi, '0, z[63:32]);
    endtask

    task automatic buildTable();
        logic [31:0] v1, v2, v3, vm, vo;
        v1 = $random(seed);
        v2 = $random(seed);
        v3 = $random(seed);
        vm = $random(seed);
        vo = $random(seed);
        // register moves, IR ra=5 rb=9
        putIn({5'd0, 4'd5, 4'd9, 19'd0});
        moveIn(ldMask(ldIr), '0);
        putIn(v1);
        moveIn('0, gA | rIn);
        putIn(v2);
        moveIn('0, gB | rIn);
        expectBus(srcGpr, gA | rOut, v1);
        expectBus(srcGpr, gB | rOut, v2);
        expectBus(srcGpr, gA | bOut, v1);           // base read of a nonzero reg
        putIn({5'd0, 4'd0, 4'd9, 4'd5, 15'd0});     // ra=0 rc=5
        moveIn(ldMask(ldIr), '0);
        putIn(v3);
        moveIn('0, gA | rIn);
        expectBus(srcGpr, gA | rOut, v3);
        expectBus(srcGpr, gA | bOut, 32'd0);        // r0 as base is zero
        expectBus(srcGpr, gC | rOut, v1);           // rc picks r5
        // C constant, negative then positive
        putIn({13'd0, 19'h41234});
        moveIn(ldMask(ldIr), '0);
        expectBus(srcConstC, '0, {{13{1'b1}}, 19'h41234});
        putIn({13'h1FFF, 19'h01234});               // upper IR bits must not leak
        moveIn(ldMask(ldIr), '0);
        expectBus(srcConstC, '0, 32'h0000_1234);
        // every opcode on random operands, then divide by zero
        for (int k = 0; k <= int'(opInc4); k++) begin
            aluCase(aluOpE'(k), $random(seed), $random(seed));
        end
        aluCase(opDiv, $random(seed), 32'd0);
        // memory round trip at 0x2C, then untouched 0x2D
        putIn(32'h2C);
        moveIn(ldMask(ldMar), '0);
        putIn(vm);
        moveIn(ldMask(ldMdr), '0);
        memStep(1'b1);
        clearStep();                                // MDR <- 0, nothing selected
        s.ld = ldMask(ldMdr);
        pushStep();
        expectBus(srcMdr, '0, 32'd0);
        memStep(1'b0);
        expectBus(srcMdr, '0, vm);
        clearStep();                                // MDR <- 0 again
        s.ld = ldMask(ldMdr);
        pushStep();
        clearStep();                                // MDR <- memory data, bus ignored
        s.ld   = ldMask(ldMdr);
        s.mdRd = 1'b1;
        pushStep();
        expectBus(srcMdr, '0, vm);
        putIn(32'h2D);
        moveIn(ldMask(ldMar), '0);
        memStep(1'b0);
        expectBus(srcMdr, '0, 32'd0);
        // outPort and specials, then reset clears all
        putIn(vo);
        moveIn(ldMask(ldHi) | ldMask(ldLo) | ldMask(ldPc) | ldMask(ldY)
               | ldMask(ldOutPort), '0);
        clearStep();
        s.chk = 2'd2;
        s.exp = vo;
        pushStep();
        expectBus(srcHi, '0, vo);
        expectBus(srcLo, '0, vo);
        expectBus(srcPc, '0, vo);
        moveIn(ldMask(ldZ), '0);                    // z = vo + vo
        clearStep();
        s.rst = 1'b1;
        pushStep();
        clearStep();
        s.chk = 2'd2;
        s.exp = 32'd0;
        pushStep();
        for (int k = 0; k <= int'(srcConstC); k++) begin
            expectBus(busSrcE'(k), gA | rOut, 32'd0);
        end
        putIn(32'h2C);                              // written before the reset
        moveIn(ldMask(ldMar), '0);
        memStep(1'b0);                              // RAM forgot all
        expectBus(srcMdr, '0, 32'd0);
    endtask

    task automatic driveStep(input stepT t);
        rstN                           <= !t.rst;
        loadEn                         <= t.ld;
        busSrc                         <= t.src;
        aluOp                          <= t.op;
        {gra, grb, grc, rin, rout, baOut} <= t.sel;
        memRead                        <= t.rd;
        memWrite                       <= t.wr;
        mdRead                         <= t.mdRd;
        inPortData                     <= t.inData;
    endtask

    task automatic waitMemDone();
        stepT idle;
        int   n;
        idle     = '0;
        idle.src = srcGpr;
        idle.op  = opAdd;
        n        = 0;
        while (memDone !== 1'b1) begin
            @(posedge clk);
            driveStep(idle);                        // request was a one-cycle pulse
            @(negedge clk);
            n++;
            if (n > memLimit) begin
                $display("memDone did not arrive within %0d cycles", memLimit);
                stopOnFailure();
            end
        end
    endtask

    task automatic applyStep(input stepT t);
        @(posedge clk);
        driveStep(t);
        @(negedge clk);                             // outputs settled mid-cycle
        if (t.chk == 2'd1) begin
            checkEq("busOut", busOut, t.exp);
        end else if (t.chk == 2'd2) begin
            checkEq("outPort", outPort, t.exp);
        end
        if (t.waitDone) begin
            waitMemDone();
        end
    endtask

    // watchdog, ten cycles per step
    initial begin
        wait (built);
        repeat (nSteps * 10 + resetCycles) @(posedge clk);
        $display("timeout, the test steps did not finish in time");
        stopOnFailure();
    end

    initial begin
        rstN       = 1'b0;
        loadEn     = '0;
        busSrc     = srcGpr;
        aluOp      = opAdd;
        {gra, grb, grc, rin, rout, baOut} = '0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        mdRead     = 1'b0;
        inPortData = '0;
        seed       = 58;
        nSteps     = 0;
        errors     = 0;
        buildTable();
        built = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < nSteps; i++) begin
            applyStep(steps[i]);
        end
        if (errors == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stopOnFailure();
        end
    end

endmodule

// File: datapath_asserts.sv
module memUnitAsserts import cpuPkg::*; (
    input logic             clk,
    input logic             rstN,
    input logic             cyc,
    input logic             stb,
    input logic             we,
    input logic [dataW-1:0] adr,
    input logic             ack,
    input logic             memDone
);

    // strobe, address and direction held until the slave acks
    stbHeld: assert property (@(posedge clk) disable iff (!rstN)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(we)))
        else $error("stb or its address moved before ack");

    // single-cycle ack, master closes the cycle right after it
    ackPulse: assert property (@(posedge clk) disable iff (!rstN)
        ack |=> (!ack && !cyc && !stb && memDone))
        else $error("ack not followed by an idle bus and memDone");

    // sync reset leaves the bus idle
    resetIdle: assert property (@(posedge clk)
        !rstN |=> (!cyc && !stb && !memDone))
        else $error("cyc, stb or memDone high after reset");

endmodule

bind memUnit memUnitAsserts uAsserts (
    .clk     (clk),
    .rstN    (rstN),
    .cyc     (wb.cyc),
    .stb     (wb.stb),
    .we      (wb.we),
    .adr     (wb.adr),
    .ack     (wb.ack),
    .memDone (memDone)
);

// File: datapath.sv
module datapath import cpuPkg::*; #(
    parameter int memWords = 256
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic [numLoads-1:0] loadEn,      // indexed by loadE
    input  busSrcE              busSrc,
    input  aluOpE               aluOp,
    input  logic                gra,
    input  logic                grb,
    input  logic                grc,
    input  logic                rin,
    input  logic                rout,
    input  logic                baOut,
    input  logic                memRead,
    input  logic                memWrite,
    input  logic                mdRead,
    input  logic [dataW-1:0]    inPortData,
    output logic [dataW-1:0]    busOut,
    output logic [dataW-1:0]    outPort,
    output logic                memDone
);

    logic [dataW-1:0]   bus;          // the one shared bus
    logic [dataW-1:0]   hi;
    logic [dataW-1:0]   lo;
    logic [dataW-1:0]   y;
    logic [2*dataW-1:0] z;
    logic [2*dataW-1:0] aluResult;
    logic [dataW-1:0]   pc;
    logic [dataW-1:0]   ir;
    logic [dataW-1:0]   inPort;
    logic [dataW-1:0]   gprOut;
    logic [dataW-1:0]   constC;
    logic [dataW-1:0]   mdrOut;

    wbIf wb ();                       // memUnit <-> RAM

    // special registers, all load on their enable bit
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi      <= '0;
            lo      <= '0;
            y       <= '0;
            z       <= '0;
            pc      <= '0;
            ir      <= '0;
            inPort  <= '0;
            outPort <= '0;
        end else begin
            if (loadEn[ldHi]) begin
                hi <= bus;
            end
            if (loadEn[ldLo]) begin
                lo <= bus;
            end
            if (loadEn[ldY]) begin
                y <= bus;
            end
            if (loadEn[ldZ]) begin
                z <= aluResult;               // y op bus
            end
            if (loadEn[ldPc]) begin
                pc <= bus;
            end
            if (loadEn[ldIr]) begin
                ir <= bus;
            end
            if (loadEn[ldInPort]) begin
                inPort <= inPortData;         // from outside, not the bus
            end
            if (loadEn[ldOutPort]) begin
                outPort <= bus;
            end
        end
    end

    // bus mux
    always_comb begin
        case (busSrc)
            srcGpr:    bus = gprOut;
            srcHi:     bus = hi;
            srcLo:     bus = lo;
            srcZHi:    bus = z[2*dataW-1:dataW];
            srcZLo:    bus = z[dataW-1:0];
            srcPc:     bus = pc;
            srcMdr:    bus = mdrOut;
            srcInPort: bus = inPort;
            srcConstC: bus = constC;
            default:   bus = '0;              // unused codes float to zero
        endcase
    end

    assign busOut = bus;

    regFile uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .gra    (gra),
        .grb    (grb),
        .grc    (grc),
        .rin    (rin),
        .rout   (rout),
        .baOut  (baOut),
        .ir     (ir),
        .busIn  (bus),
        .gprOut (gprOut),
        .constC (constC)
    );

    alu uAlu (
        .yIn    (y),
        .busIn  (bus),
        .op     (aluOp),
        .result (aluResult)
    );

    memUnit uMem (
        .clk      (clk),
        .rstN     (rstN),
        .busIn    (bus),
        .ldMar    (loadEn[ldMar]),
        .ldMdr    (loadEn[ldMdr]),
        .mdRead   (mdRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .mdrOut   (mdrOut),
        .memDone  (memDone),
        .wb       (wb)
    );

    wbRam #(
        .memWords (memWords)
    ) uRam (
        .clk  (clk),
        .rstN (rstN),
        .wb   (wb)
    );

endmodule

// File: wbRam.sv
module wbRam import cpuPkg::*; #(
    parameter int memWords = 256
) (
    input logic clk,
    input logic rstN,
    wbIf.slave  wb
);

    localparam int aw = $clog2(memWords);   // word index bits

    logic [dataW-1:0]    mem [memWords];
    logic [memWords-1:0] written;           // per-word valid, unwritten reads zero
    logic [aw-1:0]       idx;
    logic                hit;               // strobe seen, not yet acked

    assign idx = wb.adr[aw-1:0];
    assign hit = wb.cyc & wb.stb & ~wb.ack;  // one wait state, ack never repeats

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb.ack  <= 1'b0;
            written <= '0;
        end else begin
            wb.ack <= hit;                  // high exactly one cycle
            if (hit && wb.we) begin
                written[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit && wb.we) begin
            mem[idx] <= wb.datW;
        end else if (hit) begin
            wb.datR <= written[idx] ? mem[idx] : '0;  // held until next read
        end
    end

endmodule

// File: memUnit.sv
module memUnit import cpuPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  logic [dataW-1:0] busIn,
    input  logic             ldMar,
    input  logic             ldMdr,
    input  logic             mdRead,    // ldMdr takes last read word, not bus
    input  logic             memRead,   // one-cycle request
    input  logic             memWrite,  // one-cycle request
    output logic [dataW-1:0] mdrOut,
    output logic             memDone,   // one-cycle pulse at end of access
    wbIf.master              wb
);

    typedef enum logic {
        stIdle,
        stBusy
    } memStateE;

    memStateE         state;
    logic [dataW-1:0] mar;
    logic [dataW-1:0] mdr;
    logic             start;       // request accepted this cycle
    logic             rdDone;      // read data valid on wb.datR

    assign start  = (state == stIdle) & (memRead | memWrite);  // busy drops requests
    assign rdDone = (state == stBusy) & wb.ack & ~wb.we;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (ldMar) begin
                mar <= busIn;
            end
            if (rdDone) begin
                mdr <= wb.datR;                       // read result lands in MDR
            end else if (ldMdr) begin
                mdr <= mdRead ? wb.datR : busIn;
            end
        end
    end

    // FSM, one classic cycle per request
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= stIdle;
            wb.cyc  <= 1'b0;
            wb.stb  <= 1'b0;
            wb.we   <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (start) begin
                        state  <= stBusy;
                        wb.cyc <= 1'b1;             // cyc and stb rise together
                        wb.stb <= 1'b1;
                        wb.we  <= memWrite;         // write wins if both pulse
                    end
                end
                stBusy: begin
                    if (wb.ack) begin
                        state   <= stIdle;
                        wb.cyc  <= 1'b0;            // drop the cycle after ack
                        wb.stb  <= 1'b0;
                        memDone <= 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // address and write data frozen for the whole access
    always_ff @(posedge clk) begin
        if (start) begin
            wb.adr  <= mar;
            wb.datW <= mdr;
        end
    end

    assign mdrOut = mdr;

endmodule

// File: alu.sv
module alu import cpuPkg::*; (
    input  logic [dataW-1:0]   yIn,      // first operand, from Y
    input  logic [dataW-1:0]   busIn,    // second operand, straight off the bus
    input  aluOpE              op,
    output logic [2*dataW-1:0] result    // goes into Z
);

    logic [4:0]                shamt;    // shift count
    logic [dataW-1:0]          word;     // single-word result of the simple ops
    logic signed [2*dataW-1:0] prod;
    logic signed [dataW-1:0]   quot;
    logic signed [dataW-1:0]   rem;
    logic                      divZero;

    assign shamt   = busIn[4:0];         // only low five bits count
    assign divZero = (busIn == '0);

    // operands widen to 64 bits signed before the multiply
    assign prod = $signed(yIn) * $signed(busIn);

    // divide by zero: quot all ones, rem = dividend
    assign quot = divZero ? -1 : $signed(yIn) / $signed(busIn);   // signed -1 keeps divide signed
    assign rem  = divZero ? $signed(yIn) : $signed(yIn) % $signed(busIn);

    always_comb begin
        word = '0;
        case (op)
            opAdd:   word = yIn + busIn;
            opSub:   word = yIn - busIn;
            opAnd:   word = yIn & busIn;
            opOr:    word = yIn | busIn;
            opXor:   word = yIn ^ busIn;
            opShl:   word = yIn << shamt;
            opShr:   word = yIn >> shamt;               // logical
            opShra:  word = $signed(yIn) >>> shamt;     // keeps sign
            opNeg:   word = -busIn;                     // two's complement
            opNot:   word = ~busIn;
            opInc4:  word = busIn + dataW'(4);          // next word address
            default: word = '0;                         // mul / div use own path
        endcase
    end

    // wide ops fill both halves, rest sign-extend into hi
    always_comb begin
        case (op)
            opMul:   result = prod;
            opDiv:   result = {rem, quot};
            default: result = {{dataW{word[dataW-1]}}, word};
        endcase
    end

endmodule

// File: regFile.sv
module regFile import cpuPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  logic             gra,      // use Ra field
    input  logic             grb,      // use Rb field
    input  logic             grc,      // use Rc field
    input  logic             rin,
    input  logic             rout,
    input  logic             baOut,    // base-address read, r0 reads as zero
    input  logic [dataW-1:0] ir,
    input  logic [dataW-1:0] busIn,
    output logic [dataW-1:0] gprOut,
    output logic [dataW-1:0] constC
);

    // IR layout: op[31:27] ra[26:23] rb[22:19] rc[18:15], C is [18:0]
    logic [dataW-1:0] regs [16];
    logic [3:0]       field;      // selected register number
    logic [15:0]      regSel;     // one-hot of field
    logic [15:0]      regsIn;     // per-register load
    logic [15:0]      regsOut;    // per-register drive

    // field select, gra has priority
    always_comb begin
        field = 4'd0;
        if (gra) begin
            field = ir[26:23];
        end else if (grb) begin
            field = ir[22:19];
        end else if (grc) begin
            field = ir[18:15];
        end
    end

    assign regSel  = (gra | grb | grc) ? (16'b1 << field) : '0;  // nothing picked -> no reg
    assign regsIn  = rin ? regSel : '0;
    assign regsOut = (rout | baOut) ? regSel : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 16; i++) begin
                if (regsIn[i]) begin
                    regs[i] <= busIn;       // load from bus
                end
            end
        end
    end

    // and-or mux over the one-hot drive
    always_comb begin
        gprOut = '0;
        for (int i = 0; i < 16; i++) begin
            if (regsOut[i] && !(baOut && i == 0)) begin  // r0 as base = 0
                gprOut = gprOut | regs[i];
            end
        end
    end

    // 19-bit immediate, sign-extended to a word
    assign constC = {{(dataW - 19){ir[18]}}, ir[18:0]};

endmodule

// File: wbIf.sv
interface wbIf import cpuPkg::*; ();

    logic             cyc;    // cycle in progress
    logic             stb;    // strobe, valid transfer
    logic             we;     // 1 = write
    logic [dataW-1:0] adr;    // word address
    logic [dataW-1:0] datW;   // master to slave
    logic [dataW-1:0] datR;   // slave to master
    logic             ack;    // single-cycle transfer ack

    modport master (
        output cyc, stb, we, adr, datW,
        input  datR, ack
    );

    modport slave (
        input  cyc, stb, we, adr, datW,
        output datR, ack
    );

endinterface

// File: cpuPkg.sv
package cpuPkg;

    localparam int dataW    = 32;   // bus and register width, one word
    localparam int numLoads = 10;   // bits in the load-enable word

    // ALU opcodes, y op bus unless noted
    typedef enum logic [4:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opShl,
        opShr,
        opShra,
        opNeg,      // unary on bus
        opNot,      // unary on bus
        opMul,      // signed, full 64-bit product
        opDiv,      // signed, rem in hi, quot in lo
        opInc4      // unary on bus
    } aluOpE;

    // who drives the shared bus
    typedef enum logic [4:0] {
        srcGpr,     // register picked by rout / baOut
        srcHi,
        srcLo,
        srcZHi,
        srcZLo,
        srcPc,
        srcMdr,
        srcInPort,
        srcConstC   // sign-extended C field of IR
    } busSrcE;

    // bit positions inside loadEn
    typedef enum int unsigned {
        ldHi      = 0,
        ldLo      = 1,
        ldZ       = 2,
        ldY       = 3,
        ldPc      = 4,
        ldMdr     = 5,
        ldInPort  = 6,
        ldIr      = 7,
        ldMar     = 8,
        ldOutPort = 9
    } loadE;

endpackage
